/* run_sim.sh */
#!/bin/sh
# build and run the UART bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module uart_bridge_tb -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vuart_bridge_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
	echo "RESULT: PASS"
	exit 0
fi
echo "RESULT: FAIL"
exit 1

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;  // 40 ns period

endmodule

/* sim/uart_bridge_tb.sv */
`timescale 1ns/100ps

module uart_bridge_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int FRAME_CYCLES = 10 * bridge_pkg::CLKS_PER_BIT;
	localparam int QUIET_CYCLES = bridge_pkg::ACK_TIMEOUT + FRAME_CYCLES;
	localparam int WAIT_CYCLES  = bridge_pkg::ACK_TIMEOUT + 2 * FRAME_CYCLES;
	localparam int QUIET_FRAMES = QUIET_CYCLES / FRAME_CYCLES + 1;
	// frames per test in order with quiet windows counted as frames
	localparam int TEST_FRAMES  = 4 + (4 + QUIET_FRAMES) + (6 + QUIET_FRAMES)
		+ bridge_pkg::MAX_TRIES * (1 + QUIET_FRAMES) + QUIET_FRAMES + 40;
	localparam int WATCHDOG_NS  = TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD * 2;

	logic                            clk;
	logic                            reset;
	logic                            rx;
	logic                            tx;
	logic                            bus_done;
	bridge_pkg::bus_req_t            bus_req;
	logic [bridge_pkg::DATA_LEN-1:0] slave_data;
	logic                            slave_write_en;

	bridge_pkg::bus_req_t            bus_log[$];  // writes seen by the bus model
	logic [bridge_pkg::ADDR_LEN-1:0] next_addr;   // address the next write should use
	logic [31:0]                     rng_state;

	tb_clock u_clock (
		.clk (clk)
	);

	uart_bridge_top u_dut (
		.clk            (clk),
		.reset          (reset),
		.rx             (rx),
		.tx             (tx),
		.bus_done       (bus_done),
		.bus_req        (bus_req),
		.slave_data     (slave_data),
		.slave_write_en (slave_write_en)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stop_run($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
	endtask

	// drives one 8N1 frame on rx from a falling edge
	task automatic host_send(input logic [bridge_pkg::DATA_LEN-1:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			rx = frame[i];
			repeat (bridge_pkg::CLKS_PER_BIT) @(negedge clk);
		end
	endtask

	// returns at the middle of the stop bit
	task automatic host_expect(input string name, output logic [bridge_pkg::DATA_LEN-1:0] data);
		int waited;
		int i;
		waited = 0;
		data   = '0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < WAIT_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (tx !== 1'b0)
			stop_run($sformatf("%s: no frame started on tx within %0d cycles", name, WAIT_CYCLES));
		else
		begin
			repeat (bridge_pkg::CLKS_PER_BIT / 2) @(negedge clk);
			check_value({name, "_start_bit"}, 0, 32'(tx));
			for (i = 0; i < bridge_pkg::DATA_LEN; i++)
			begin
				repeat (bridge_pkg::CLKS_PER_BIT) @(negedge clk);
				data[i] = tx;  // lsb first
			end
			repeat (bridge_pkg::CLKS_PER_BIT) @(negedge clk);
			check_value({name, "_stop_bit"}, 1, 32'(tx));
		end
	endtask

	task automatic expect_silence(input string name, input int cycles);
		int n;
		n = 0;
		while (n < cycles && tx === 1'b1)
		begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b1)
			stop_run($sformatf("%s: a frame appeared on tx while the line should stay idle", name));
	endtask

	task automatic check_bus_write(input string name, input logic [bridge_pkg::DATA_LEN-1:0] b);
		bridge_pkg::bus_req_t req;
		check_value({name, "_write_count"}, 1, bus_log.size());
		req = bus_log.pop_front();
		check_value({name, "_op"}, 32'(bridge_pkg::BUS_WRITE), 32'(req.op));
		check_value({name, "_slave_sel"}, 1, 32'(req.slave_sel));
		check_value({name, "_addr"}, 32'(next_addr), 32'(req.addr));
		check_value({name, "_data"}, 32'(b), 32'(req.data));
		check_value({name, "_burst"}, 0, 32'(req.burst));
		next_addr = next_addr + 1'b1;
	endtask

	// sends a host data byte and expects the ack and one bus write
	task automatic send_data_byte(input string name, input logic [bridge_pkg::DATA_LEN-1:0] b);
		logic [bridge_pkg::DATA_LEN-1:0] got;
		fork
			host_send(b);
			host_expect(name, got);
		join
		check_value({name, "_ack"}, 32'(bridge_pkg::ACK_BYTE), 32'(got));
		check_bus_write(name, b);
	endtask

	task automatic check_reset_idle();
		check_value("reset_idle_tx", 1, 32'(tx));
		check_value("reset_idle_op", 32'(bridge_pkg::BUS_IDLE), 32'(bus_req.op));
	endtask

	task automatic host_write_pair();
		send_data_byte("host_write_pair_0", 8'h3A);
		send_data_byte("host_write_pair_1", 8'hC5);
	endtask

	task automatic forward_with_ack();
		logic [bridge_pkg::DATA_LEN-1:0] got;
		slave_data     = 8'h96;
		slave_write_en = 1'b1;
		host_expect("forward_with_ack", got);
		check_value("forward_with_ack_data", 32'h96, 32'(got));
		host_send(bridge_pkg::ACK_BYTE);
		expect_silence("forward_with_ack", QUIET_CYCLES);
		check_value("forward_with_ack_no_write", 0, bus_log.size());
		slave_write_en = 1'b0;
		repeat (2) @(negedge clk);
		send_data_byte("forward_with_ack_idle", 8'h17);  // acked only from idle
	endtask

	task automatic forward_with_nack();
		logic [bridge_pkg::DATA_LEN-1:0] got;
		time                             start_ns;
		slave_data     = 8'h5A;
		slave_write_en = 1'b1;
		host_expect("forward_with_nack_first", got);
		check_value("forward_with_nack_first", 32'h5A, 32'(got));
		start_ns = $time;
		fork
			host_send(8'h21);  // any byte but the ack
			host_expect("forward_with_nack_retry", got);
		join
		check_value("forward_with_nack_retry", 32'h5A, 32'(got));
		// a resend caused by the timeout would come much later
		if ($time - start_ns >= bridge_pkg::ACK_TIMEOUT * CLK_PERIOD)
			stop_run("forward_with_nack: the non-ack byte did not cause a resend before the timeout");
		check_bus_write("forward_with_nack_bus", 8'h21);  // the nack is also host data
		host_send(bridge_pkg::ACK_BYTE);
		expect_silence("forward_with_nack", QUIET_CYCLES);
		slave_write_en = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic forward_no_answer();
		logic [bridge_pkg::DATA_LEN-1:0] got;
		int                              i;
		slave_data     = 8'hE1;
		slave_write_en = 1'b1;
		for (i = 0; i < bridge_pkg::MAX_TRIES; i++)
		begin
			host_expect($sformatf("forward_no_answer_%0d", i), got);
			check_value($sformatf("forward_no_answer_%0d", i), 32'hE1, 32'(got));
		end
		expect_silence("forward_no_answer", QUIET_CYCLES);
		check_value("forward_no_answer_no_write", 0, bus_log.size());
		slave_write_en = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic random_host_writes();
		logic [bridge_pkg::DATA_LEN-1:0] b;
		int                              i;
		for (i = 0; i < 20; i++)
		begin
			do
			begin
				rng_state = next_random(rng_state);
				b         = rng_state[7:0];
			end
			while (b == bridge_pkg::ACK_BYTE);  // the ack code is not host data
			send_data_byte($sformatf("random_host_writes_%0d", i), b);
		end
	endtask

	// bus model that completes each write a few cycles after it shows up
	initial
	begin
		bus_done = 1'b0;
		forever
		begin
			@(negedge clk);
			if (bus_req.op == bridge_pkg::BUS_WRITE)
			begin
				bus_log.push_back(bus_req);
				repeat (3) @(negedge clk);
				bus_done = 1'b1;
				@(negedge clk);
				bus_done = 1'b0;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before all tests finished");
	end

	initial
	begin
		rx             = 1'b1;  // line idles high
		slave_data     = '0;
		slave_write_en = 1'b0;
		reset          = 1'b1;
		next_addr      = '0;
		rng_state      = 32'd19409;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_reset_idle();
		host_write_pair();
		forward_with_ack();
		forward_with_nack();
		forward_no_answer();
		random_host_writes();
		$display("All checks passed");
		$finish;
	end

endmodule

/* verilog.f */
verilog/bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/bus_write_master.sv
verilog/uart_link_ctrl.sv
verilog/uart_bridge_top.sv
sim/tb_clock.sv
sim/uart_bridge_tb.sv

/* verilog/bridge_pkg.sv */
package bridge_pkg;

	localparam int DATA_LEN     = 8;
	localparam int ADDR_LEN     = 12;
	localparam int SLAVE_LEN    = 2;
	localparam int BURST_LEN    = 12;
	localparam int CLKS_PER_BIT = 8;    // kept small for simulation
	localparam int ACK_TIMEOUT  = 400;  // cycles to wait for the host ack
	localparam int MAX_TRIES    = 5;

	localparam logic [DATA_LEN-1:0] ACK_BYTE = 8'hCC;

	// counter widths and their terminal values
	localparam int BIT_CNT_LEN = $clog2(CLKS_PER_BIT);
	localparam int TIMEOUT_LEN = $clog2(ACK_TIMEOUT);
	localparam int TRY_LEN     = $clog2(MAX_TRIES + 1);
	localparam logic [BIT_CNT_LEN-1:0] BIT_LAST     = BIT_CNT_LEN'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_LEN-1:0] BIT_HALF     = BIT_CNT_LEN'(CLKS_PER_BIT / 2 - 1);
	localparam logic [TIMEOUT_LEN-1:0] TIMEOUT_LAST = TIMEOUT_LEN'(ACK_TIMEOUT - 1);
	localparam logic [TRY_LEN-1:0]     TRY_MAX      = TRY_LEN'(MAX_TRIES);

	typedef enum logic [1:0] {BUS_IDLE = 2'b00, BUS_READ = 2'b01, BUS_WRITE = 2'b10} bus_op_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
	typedef enum logic {WR_IDLE, WR_BUSY} wr_state_t;
	typedef enum logic [2:0] {
		LINK_IDLE,
		LINK_ACK_OUT,
		LINK_DATA_OUT,
		LINK_ACK_WAIT,
		LINK_HOLD
	} link_state_t;

	typedef struct packed {
		logic                valid;   // one-cycle strobe
		logic                is_ack;
		logic [DATA_LEN-1:0] data;
	} rx_byte_t;

	typedef struct packed {
		logic                start;
		logic [DATA_LEN-1:0] data;
	} tx_req_t;

	typedef struct packed {
		bus_op_t              op;
		logic [SLAVE_LEN-1:0] slave_sel;
		logic [ADDR_LEN-1:0]  addr;
		logic [DATA_LEN-1:0]  data;
		logic [BURST_LEN-1:0] burst;
	} bus_req_t;

endpackage

/* verilog/bus_write_master.sv */
`timescale 1ns/100ps

module bus_write_master (
	input  logic                 clk,
	input  logic                 reset,
	input  bridge_pkg::rx_byte_t rx_byte,
	input  logic                 bus_done,
	output bridge_pkg::bus_req_t bus_req
);

	bridge_pkg::wr_state_t             state;
	logic [bridge_pkg::ADDR_LEN-1:0]   addr;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= bridge_pkg::WR_IDLE;
			addr    <= '0;
			bus_req <= '{op: bridge_pkg::BUS_IDLE, default: '0};
		end
		else
		begin
			case (state)
				bridge_pkg::WR_IDLE:
					if (rx_byte.valid && !rx_byte.is_ack)
					begin
						bus_req.op        <= bridge_pkg::BUS_WRITE;
						bus_req.slave_sel <= {{(bridge_pkg::SLAVE_LEN-1){1'b0}}, 1'b1};
						bus_req.addr      <= addr;
						bus_req.data      <= rx_byte.data;
						bus_req.burst     <= '0;  // single beat
						state             <= bridge_pkg::WR_BUSY;
					end
				bridge_pkg::WR_BUSY:
					if (bus_done)  // bytes arriving before this are lost
					begin
						bus_req.op <= bridge_pkg::BUS_IDLE;
						addr       <= addr + 1'b1;  // wraps at 4096
						state      <= bridge_pkg::WR_IDLE;
					end
				default: state <= bridge_pkg::WR_IDLE;
			endcase
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(state == bridge_pkg::WR_BUSY && !bus_done) |=> $stable(bus_req))
		else $error("bus request changed before bus_done");

endmodule

/* verilog/uart_bridge_top.sv */
`timescale 1ns/100ps

module uart_bridge_top (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            rx,
	output logic                            tx,
	input  logic                            bus_done,
	output bridge_pkg::bus_req_t            bus_req,
	input  logic [bridge_pkg::DATA_LEN-1:0] slave_data,
	input  logic                            slave_write_en
);

	bridge_pkg::rx_byte_t rx_byte;  // shared by bus engine and link
	bridge_pkg::tx_req_t  tx_req;
	logic                 tx_busy;
	logic                 tx_done;

	uart_rx u_rx (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.rx_byte (rx_byte)
	);

	bus_write_master u_bus_write (
		.clk      (clk),
		.reset    (reset),
		.rx_byte  (rx_byte),
		.bus_done (bus_done),
		.bus_req  (bus_req)
	);

	uart_link_ctrl u_link (
		.clk            (clk),
		.reset          (reset),
		.rx_byte        (rx_byte),
		.slave_data     (slave_data),
		.slave_write_en (slave_write_en),
		.tx_busy        (tx_busy),
		.tx_done        (tx_done),
		.tx_req         (tx_req)
	);

	uart_tx u_tx (
		.clk     (clk),
		.reset   (reset),
		.tx_req  (tx_req),
		.tx      (tx),
		.tx_busy (tx_busy),
		.tx_done (tx_done)
	);

endmodule

/* verilog/uart_link_ctrl.sv */
`timescale 1ns/100ps

module uart_link_ctrl (
	input  logic                            clk,
	input  logic                            reset,
	input  bridge_pkg::rx_byte_t            rx_byte,
	input  logic [bridge_pkg::DATA_LEN-1:0] slave_data,
	input  logic                            slave_write_en,
	input  logic                            tx_busy,
	input  logic                            tx_done,
	output bridge_pkg::tx_req_t             tx_req
);

	bridge_pkg::link_state_t              state;
	logic [bridge_pkg::TRY_LEN-1:0]       tries;  // transmissions of the current slave byte
	logic [bridge_pkg::TIMEOUT_LEN-1:0]   timer;
	logic                                 host_data, ack_seen, nack_seen, timed_out;

	assign host_data = rx_byte.valid && !rx_byte.is_ack;
	assign ack_seen  = rx_byte.valid && rx_byte.is_ack;
	assign nack_seen = host_data;
	assign timed_out = !rx_byte.valid && (timer == bridge_pkg::TIMEOUT_LAST);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state  <= bridge_pkg::LINK_IDLE;
			tries  <= '0;
			timer  <= '0;
			tx_req <= '0;
		end
		else
		begin
			tx_req.start <= 1'b0;
			case (state)
				bridge_pkg::LINK_IDLE:
					if (host_data && !tx_busy)
					begin
						// host bytes are answered first
						tx_req.start <= 1'b1;
						tx_req.data  <= bridge_pkg::ACK_BYTE;
						state        <= bridge_pkg::LINK_ACK_OUT;
					end
					else if (slave_write_en && !tx_busy)
					begin
						tx_req.start <= 1'b1;
						tx_req.data  <= slave_data;  // kept here for retries
						tries        <= {{(bridge_pkg::TRY_LEN-1){1'b0}}, 1'b1};
						state        <= bridge_pkg::LINK_DATA_OUT;
					end
				bridge_pkg::LINK_ACK_OUT:
					if (tx_done)
						state <= bridge_pkg::LINK_IDLE;
				bridge_pkg::LINK_DATA_OUT:
					if (tx_done)
					begin
						timer <= '0;
						state <= bridge_pkg::LINK_ACK_WAIT;
					end
				bridge_pkg::LINK_ACK_WAIT:
				begin
					timer <= timer + 1'b1;
					if (ack_seen)
					begin
						tries <= '0;
						state <= slave_write_en ? bridge_pkg::LINK_HOLD : bridge_pkg::LINK_IDLE;
					end
					else if (nack_seen || timed_out)
					begin
						if (tries == bridge_pkg::TRY_MAX)
						begin
							// give up on this byte
							tries <= '0;
							state <= slave_write_en ? bridge_pkg::LINK_HOLD
							                        : bridge_pkg::LINK_IDLE;
						end
						else
						begin
							tx_req.start <= 1'b1;  // resend same data
							tries        <= tries + 1'b1;
							state        <= bridge_pkg::LINK_DATA_OUT;
						end
					end
				end
				bridge_pkg::LINK_HOLD:
					if (!slave_write_en)  // wait for the slave to drop its request
						state <= bridge_pkg::LINK_IDLE;
				default: state <= bridge_pkg::LINK_IDLE;
			endcase
		end
	end

	a_tries_bound: assert property (@(posedge clk) disable iff (reset)
		tries <= bridge_pkg::TRY_MAX)
		else $error("try count above MAX_TRIES");

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
	input  logic                clk,
	input  logic                reset,
	input  logic                rx,
	output bridge_pkg::rx_byte_t rx_byte
);

	bridge_pkg::rx_state_t                   state;
	logic                                    rx_meta, rx_sync;
	logic [bridge_pkg::BIT_CNT_LEN-1:0]      cnt;
	logic [2:0]                              bit_idx;
	logic [bridge_pkg::DATA_LEN-1:0]         shift;

	// two-flop synchronizer that idles high like the line
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= bridge_pkg::RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			rx_byte <= '0;
		end
		else
		begin
			rx_byte.valid <= 1'b0;
			case (state)
				bridge_pkg::RX_IDLE:
				begin
					cnt <= '0;
					if (!rx_sync)
						state <= bridge_pkg::RX_START;
				end
				bridge_pkg::RX_START:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == bridge_pkg::BIT_HALF)
					begin
						cnt     <= '0;
						bit_idx <= '0;
						// a glitch shorter than half a bit is ignored
						state   <= rx_sync ? bridge_pkg::RX_IDLE : bridge_pkg::RX_DATA;
					end
				end
				bridge_pkg::RX_DATA:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == bridge_pkg::BIT_LAST)
					begin
						cnt     <= '0;
						shift   <= {rx_sync, shift[bridge_pkg::DATA_LEN-1:1]};  // lsb first
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= bridge_pkg::RX_STOP;
					end
				end
				bridge_pkg::RX_STOP:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == bridge_pkg::BIT_LAST)
					begin
						state <= bridge_pkg::RX_IDLE;
						if (rx_sync)  // framing error drops the byte
						begin
							rx_byte.valid  <= 1'b1;
							rx_byte.is_ack <= (shift == bridge_pkg::ACK_BYTE);
							rx_byte.data   <= shift;
						end
					end
				end
				default: state <= bridge_pkg::RX_IDLE;
			endcase
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_byte.valid |=> !rx_byte.valid)
		else $error("rx_byte.valid held for two cycles");

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
	input  logic                clk,
	input  logic                reset,
	input  bridge_pkg::tx_req_t tx_req,
	output logic                tx,
	output logic                tx_busy,
	output logic                tx_done
);

	bridge_pkg::tx_state_t               state;
	logic [bridge_pkg::BIT_CNT_LEN-1:0]  cnt;
	logic [2:0]                          bit_idx;
	logic [bridge_pkg::DATA_LEN-1:0]     shift;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= bridge_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
			tx_busy <= 1'b0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (state != bridge_pkg::TX_IDLE)
				cnt <= cnt + 1'b1;
			case (state)
				bridge_pkg::TX_IDLE:
				begin
					cnt <= '0;
					if (tx_req.start)
					begin
						shift   <= tx_req.data;
						tx      <= 1'b0;  // start bit
						tx_busy <= 1'b1;
						state   <= bridge_pkg::TX_START;
					end
				end
				bridge_pkg::TX_START:
					if (cnt == bridge_pkg::BIT_LAST)
					begin
						tx      <= shift[0];
						bit_idx <= '0;
						state   <= bridge_pkg::TX_DATA;
					end
				bridge_pkg::TX_DATA:
					if (cnt == bridge_pkg::BIT_LAST)
					begin
						if (bit_idx == 3'd7)
						begin
							tx    <= 1'b1;  // stop bit
							state <= bridge_pkg::TX_STOP;
						end
						else
						begin
							tx      <= shift[bit_idx + 1'b1];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				bridge_pkg::TX_STOP:
					if (cnt == bridge_pkg::BIT_LAST)
					begin
						tx_done <= 1'b1;
						tx_busy <= 1'b0;
						state   <= bridge_pkg::TX_IDLE;
					end
				default: state <= bridge_pkg::TX_IDLE;
			endcase
		end
	end

	// the link controller must wait for tx_done before the next start
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		tx_req.start |-> !tx_busy)
		else $error("transmit start while busy");

endmodule
